//--- include/periph_defs.svh
`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

// -----------------------------------------------
// Bus geometry
// -----------------------------------------------
`define PERIPH_DATA_W       32

// -----------------------------------------------
// Interrupt sources
// -----------------------------------------------
// Source 0 is the timer, sources 1 to 7 are the external lines
`define PERIPH_NUM_EXT_IRQ  7
`define PERIPH_NUM_SRC      8

// Read word returned by slots with no peripheral behind them
`define PERIPH_ERR_WORD     32'hDEADBEEF

// -----------------------------------------------
// Register indices, word granular
// -----------------------------------------------
`define PERIPH_REG_CTRL     4'd0
`define PERIPH_REG_COUNT    4'd1
`define PERIPH_REG_CMP      4'd2

`define PERIPH_REG_ENABLE   4'd0
`define PERIPH_REG_PENDING  4'd1
`define PERIPH_REG_CLAIM    4'd2

`endif

//--- hw/periph_pkg.sv
`include "periph_defs.svh"

package periph_pkg;

    // -----------------------------------------------
    // Target slots
    // -----------------------------------------------
    // Slots 2 and 3 have no peripheral and answer with an error
    typedef enum logic [1:0] {
        SLOT_IRQ    = 2'd0,
        SLOT_TIMER  = 2'd1,
        SLOT_NONE_A = 2'd2,
        SLOT_NONE_B = 2'd3
    } periph_slot_e;

    // -----------------------------------------------
    // Bus address
    // -----------------------------------------------
    // Field view routes the access, raw view is the plain word
    typedef union packed {
        struct packed {
            logic [17:0]  unused_hi;
            periph_slot_e slot;
            logic [5:0]   unused_mid;
            logic [3:0]   reg_idx;
            logic [1:0]   byte_off;
        } fld;
        logic [`PERIPH_DATA_W-1:0] raw;
    } periph_addr_u;

endpackage

//--- hw/periph_addr_decode.sv
`timescale 1ns/1ps

module periph_addr_decode (
    input  logic                     psel_i,
    input  logic                     penable_i,
    input  logic                     pwrite_i,
    input  periph_pkg::periph_addr_u paddr_i,
    output logic                     tmr_we_o,
    output logic                     irq_we_o,
    output logic                     irq_re_o,
    output logic [3:0]               reg_idx_o,
    output periph_pkg::periph_slot_e slot_o,
    output logic                     err_o
);

    logic access;
    logic absent;
    logic misaligned;
    logic hit_timer;
    logic hit_irq;

    // Access phase of a transfer, the only cycle that acts
    assign access = psel_i && penable_i;

    assign slot_o    = paddr_i.fld.slot;
    assign reg_idx_o = paddr_i.fld.reg_idx;

    assign absent = (paddr_i.fld.slot == periph_pkg::SLOT_NONE_A) ||
                    (paddr_i.fld.slot == periph_pkg::SLOT_NONE_B);

    // Only whole-word accesses are supported
    assign misaligned = (paddr_i.raw[1:0] != 2'b00);

    assign err_o = access && (absent || misaligned);

    assign hit_timer = access && !err_o && (paddr_i.fld.slot == periph_pkg::SLOT_TIMER);
    assign hit_irq   = access && !err_o && (paddr_i.fld.slot == periph_pkg::SLOT_IRQ);

    // -----------------------------------------------
    // Per-target strobes
    // -----------------------------------------------
    assign tmr_we_o = hit_timer && pwrite_i;
    assign irq_we_o = hit_irq && pwrite_i;
    // Claim reads change state, so the gateway needs a read strobe
    assign irq_re_o = hit_irq && !pwrite_i;

    // Access phase is only entered from a setup phase with psel already up
    access_after_setup: assert property (@(posedge penable_i) psel_i)
        else $error("access phase began without a setup phase");

endmodule

//--- hw/periph_timer.sv
`timescale 1ns/1ps
`include "periph_defs.svh"

module periph_timer (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      we_i,
    input  logic [3:0]                reg_idx_i,
    input  logic [`PERIPH_DATA_W-1:0] wdata_i,
    output logic [`PERIPH_DATA_W-1:0] rdata_o,
    output logic                      irq_o
);

    logic                      en_q;
    logic [`PERIPH_DATA_W-1:0] count_q;
    logic [`PERIPH_DATA_W-1:0] cmp_q;
    logic                      irq_q;
    logic                      ctrl_we;
    logic                      cmp_we;
    logic                      match;

    assign ctrl_we = we_i && (reg_idx_i == `PERIPH_REG_CTRL);
    assign cmp_we  = we_i && (reg_idx_i == `PERIPH_REG_CMP);
    assign match   = en_q && (count_q == cmp_q);

    // -----------------------------------------------
    // Counter and compare
    // -----------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            en_q    <= 1'b0;
            count_q <= '0;
            cmp_q   <= '0;
            irq_q   <= 1'b0;
        end else if (ctrl_we) begin
            // CTRL write acknowledges the interrupt and restarts the count
            en_q    <= wdata_i[0];
            count_q <= '0;
            irq_q   <= 1'b0;
        end else begin
            if (match) begin
                irq_q <= 1'b1;
            end
            if (cmp_we) begin
                // Restart the period on a new compare value
                cmp_q   <= wdata_i;
                count_q <= '0;
            end else if (match) begin
                count_q <= '0;
            end else if (en_q) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    // -----------------------------------------------
    // Register read
    // -----------------------------------------------
    always_comb begin
        case (reg_idx_i)
            `PERIPH_REG_CTRL:  rdata_o = {{(`PERIPH_DATA_W-1){1'b0}}, en_q};
            `PERIPH_REG_COUNT: rdata_o = count_q;
            `PERIPH_REG_CMP:   rdata_o = cmp_q;
            default:           rdata_o = '0;
        endcase
    end

    assign irq_o = irq_q;

    // Count wraps at the compare value and never runs past it
    cnt_bound: assert property (@(posedge clk_i) disable iff (rst_i)
        (en_q && (cmp_q != '0)) |=> (count_q <= cmp_q))
        else $error("timer count passed the compare value");

endmodule

//--- hw/periph_irq_gateway.sv
`timescale 1ns/1ps
`include "periph_defs.svh"

module periph_irq_gateway (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          we_i,
    input  logic                          re_i,
    input  logic [3:0]                    reg_idx_i,
    input  logic [`PERIPH_DATA_W-1:0]     wdata_i,
    input  logic                          timer_irq_i,
    input  logic [`PERIPH_NUM_EXT_IRQ-1:0] ext_irq_i,
    output logic [`PERIPH_DATA_W-1:0]     rdata_o,
    output logic                          irq_o
);

    // Ids run from 1 to the source count, 0 means nothing to claim
    localparam int ID_W = $clog2(`PERIPH_NUM_SRC + 1);

    logic [`PERIPH_NUM_SRC-1:0] src;
    logic [`PERIPH_NUM_SRC-1:0] enable_q;
    logic [`PERIPH_NUM_SRC-1:0] in_service_q;
    logic [`PERIPH_NUM_SRC-1:0] claimable;
    logic [`PERIPH_NUM_SRC-1:0] claim_mask;
    logic [`PERIPH_NUM_SRC-1:0] complete_mask;
    logic [ID_W-1:0]            claim_id;
    logic                       claim_fire;
    logic                       irq_q;

    assign src       = {ext_irq_i, timer_irq_i};
    assign claimable = src & enable_q & ~in_service_q;

    // -----------------------------------------------
    // Lowest pending source wins the claim
    // -----------------------------------------------
    always_comb begin
        claim_id   = '0;
        claim_mask = '0;
        for (int i = `PERIPH_NUM_SRC - 1; i >= 0; i--) begin
            if (claimable[i]) begin
                claim_id   = ID_W'(i + 1);
                claim_mask = `PERIPH_NUM_SRC'(1) << i;
            end
        end
    end

    assign claim_fire = re_i && (reg_idx_i == `PERIPH_REG_CLAIM) && (claim_id != '0);

    // Completion names the source by its id
    always_comb begin
        complete_mask = '0;
        for (int i = 0; i < `PERIPH_NUM_SRC; i++) begin
            complete_mask[i] = we_i && (reg_idx_i == `PERIPH_REG_CLAIM) &&
                               (wdata_i == `PERIPH_DATA_W'(i + 1));
        end
    end

    // -----------------------------------------------
    // State
    // -----------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            enable_q     <= '0;
            in_service_q <= '0;
            irq_q        <= 1'b0;
        end else begin
            if (we_i && (reg_idx_i == `PERIPH_REG_ENABLE)) begin
                enable_q <= wdata_i[`PERIPH_NUM_SRC-1:0];
            end
            in_service_q <= (in_service_q | (claim_fire ? claim_mask : '0)) & ~complete_mask;
            irq_q        <= |claimable;
        end
    end

    always_comb begin
        case (reg_idx_i)
            `PERIPH_REG_ENABLE:  rdata_o = `PERIPH_DATA_W'(enable_q);
            `PERIPH_REG_PENDING: rdata_o = `PERIPH_DATA_W'(src);
            `PERIPH_REG_CLAIM:   rdata_o = `PERIPH_DATA_W'(claim_id);
            default:             rdata_o = '0;
        endcase
    end

    assign irq_o = irq_q;

    // A claim adds exactly one fresh source to the in-service set
    claim_fresh: assert property (@(posedge clk_i) disable iff (rst_i)
        (claim_fire && !we_i) |=>
            ($countones(in_service_q) == $countones($past(in_service_q)) + 1))
        else $error("claim hit a source already in service");

endmodule

//--- hw/periph_resp_mux.sv
`timescale 1ns/1ps
`include "periph_defs.svh"

module periph_resp_mux (
    input  periph_pkg::periph_slot_e  slot_i,
    input  logic                      err_i,
    input  logic [`PERIPH_DATA_W-1:0] tmr_rdata_i,
    input  logic [`PERIPH_DATA_W-1:0] irq_rdata_i,
    output logic [`PERIPH_DATA_W-1:0] prdata_o,
    output logic                      pslverr_o
);

    // -----------------------------------------------
    // Read data by slot
    // -----------------------------------------------
    always_comb begin
        case (slot_i)
            periph_pkg::SLOT_IRQ:   prdata_o = irq_rdata_i;
            periph_pkg::SLOT_TIMER: prdata_o = tmr_rdata_i;
            // Absent peripherals answer with the marker word
            default:                prdata_o = `PERIPH_ERR_WORD;
        endcase
    end

    // Decoder already flags absent slots and misaligned words
    assign pslverr_o = err_i;

endmodule

//--- hw/ariane_periph_top.sv
`timescale 1ns/1ps
`include "periph_defs.svh"

module ariane_periph_top (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           psel_i,
    input  logic                           penable_i,
    input  logic                           pwrite_i,
    input  logic [`PERIPH_DATA_W-1:0]      paddr_i,
    input  logic [`PERIPH_DATA_W-1:0]      pwdata_i,
    output logic [`PERIPH_DATA_W-1:0]      prdata_o,
    output logic                           pready_o,
    output logic                           pslverr_o,
    input  logic [`PERIPH_NUM_EXT_IRQ-1:0] ext_irq_i,
    output logic                           irq_o
);

    logic                      tmr_we;
    logic                      irq_we;
    logic                      irq_re;
    logic [3:0]                reg_idx;
    periph_pkg::periph_slot_e  slot;
    logic                      dec_err;
    logic [`PERIPH_DATA_W-1:0] tmr_rdata;
    logic [`PERIPH_DATA_W-1:0] irq_rdata;
    logic                      timer_irq;

    // Zero wait states, every access phase completes
    assign pready_o = psel_i && penable_i;

    periph_addr_decode i_decode (
        .psel_i    ( psel_i    ),
        .penable_i ( penable_i ),
        .pwrite_i  ( pwrite_i  ),
        .paddr_i   ( paddr_i   ),
        .tmr_we_o  ( tmr_we    ),
        .irq_we_o  ( irq_we    ),
        .irq_re_o  ( irq_re    ),
        .reg_idx_o ( reg_idx   ),
        .slot_o    ( slot      ),
        .err_o     ( dec_err   )
    );

    periph_timer i_timer (
        .clk_i     ( clk_i     ),
        .rst_i     ( rst_i     ),
        .we_i      ( tmr_we    ),
        .reg_idx_i ( reg_idx   ),
        .wdata_i   ( pwdata_i  ),
        .rdata_o   ( tmr_rdata ),
        .irq_o     ( timer_irq )
    );

    periph_irq_gateway i_gateway (
        .clk_i       ( clk_i     ),
        .rst_i       ( rst_i     ),
        .we_i        ( irq_we    ),
        .re_i        ( irq_re    ),
        .reg_idx_i   ( reg_idx   ),
        .wdata_i     ( pwdata_i  ),
        .timer_irq_i ( timer_irq ),
        .ext_irq_i   ( ext_irq_i ),
        .rdata_o     ( irq_rdata ),
        .irq_o       ( irq_o     )
    );

    periph_resp_mux i_resp (
        .slot_i      ( slot      ),
        .err_i       ( dec_err   ),
        .tmr_rdata_i ( tmr_rdata ),
        .irq_rdata_i ( irq_rdata ),
        .prdata_o    ( prdata_o  ),
        .pslverr_o   ( pslverr_o )
    );

endmodule

//--- testbench/tb_ariane_periph.sv
`timescale 1ns/1ps
`include "periph_defs.svh"

module tb_ariane_periph;

    localparam int    CLK_PERIOD   = 8;
    localparam int    RESET_CYCLES = 5;
    localparam int    CYCLES_PER_VEC = 64;
    localparam string VEC_FILE     = "testbench/periph_vectors.txt";

    logic                           clk_i;
    logic                           rst_i;
    logic                           psel_i;
    logic                           penable_i;
    logic                           pwrite_i;
    logic [`PERIPH_DATA_W-1:0]      paddr_i;
    logic [`PERIPH_DATA_W-1:0]      pwdata_i;
    logic [`PERIPH_DATA_W-1:0]      prdata_o;
    logic                           pready_o;
    logic                           pslverr_o;
    logic [`PERIPH_NUM_EXT_IRQ-1:0] ext_irq_i;
    logic                           irq_o;

    // Vector table, one entry per data line of the file
    // Kind 0 is a read, 1 a write and 2 an idle wait
    int unsigned               kind_q[$];
    int unsigned               wait_q[$];
    logic [`PERIPH_DATA_W-1:0] addr_q[$];
    logic [`PERIPH_DATA_W-1:0] wdata_q[$];
    logic [`PERIPH_DATA_W-1:0] ext_q[$];
    logic [`PERIPH_DATA_W-1:0] rdata_q[$];
    logic [`PERIPH_DATA_W-1:0] err_q[$];
    logic [`PERIPH_DATA_W-1:0] irq_exp_q[$];

    int unsigned limit_cycles;
    logic        vectors_ready;
    int          cur_vec;
    int unsigned seed_dummy;

    ariane_periph_top i_dut (
        .clk_i     ( clk_i     ),
        .rst_i     ( rst_i     ),
        .psel_i    ( psel_i    ),
        .penable_i ( penable_i ),
        .pwrite_i  ( pwrite_i  ),
        .paddr_i   ( paddr_i   ),
        .pwdata_i  ( pwdata_i  ),
        .prdata_o  ( prdata_o  ),
        .pready_o  ( pready_o  ),
        .pslverr_o ( pslverr_o ),
        .ext_irq_i ( ext_irq_i ),
        .irq_o     ( irq_o     )
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // Checking
    // --------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch on %s in vector %0d: got %h, expected %h",
                     name, cur_vec, actual, expected);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic load_vectors();
        int                    fd;
        int                    n;
        int                    rc;
        int                    wait_n;
        logic [63:0]           op_tok;
        logic [8*160-1:0]      skip_buf;
        logic [31:0]           a;
        logic [31:0]           w;
        logic [31:0]           e;
        logic [31:0]           r;
        logic [31:0]           s;
        logic [31:0]           q;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the vector file %s", VEC_FILE);
            $display("Simulation FAILED");
            $fatal(1);
        end
        while ($fscanf(fd, "%s", op_tok) == 1) begin
            if (op_tok == "#") begin
                // Rest of a comment line
                rc = $fgets(skip_buf, fd);
            end else begin
                n = $fscanf(fd, "%h %h %h %h %h %h", a, w, e, r, s, q);
                if (n != 6) begin
                    $display("Vector file line %0d has missing fields", kind_q.size());
                    $display("Simulation FAILED");
                    $fatal(1);
                end
                wait_n = 0;
                if (op_tok == "R") begin
                    kind_q.push_back(0);
                end else if (op_tok == "W") begin
                    kind_q.push_back(1);
                end else begin
                    kind_q.push_back(2);
                    rc = $sscanf(op_tok, "%d", wait_n);
                end
                wait_q.push_back(wait_n);
                addr_q.push_back(a);
                wdata_q.push_back(w);
                ext_q.push_back(e);
                rdata_q.push_back(r);
                err_q.push_back(s);
                irq_exp_q.push_back(q);
            end
        end
        $fclose(fd);
    endtask

    // --------------------------------------------------
    // Bus driver
    // --------------------------------------------------
    task automatic run_transfer(input int idx);
        int unsigned gap;
        @(posedge clk_i);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= (kind_q[idx] == 1);
        paddr_i   <= addr_q[idx];
        pwdata_i  <= wdata_q[idx];
        ext_irq_i <= ext_q[idx][`PERIPH_NUM_EXT_IRQ-1:0];
        @(posedge clk_i);
        penable_i <= 1'b1;
        // Middle of the access cycle
        @(negedge clk_i);
        check_value("pready_o", {31'b0, pready_o}, 32'd1);
        check_value("pslverr_o", {31'b0, pslverr_o}, err_q[idx]);
        check_value("irq_o", {31'b0, irq_o}, irq_exp_q[idx]);
        // Write responses are only compared where a value is given
        if ((kind_q[idx] == 0) || (rdata_q[idx] != '0)) begin
            check_value("prdata_o", prdata_o, rdata_q[idx]);
        end
        @(posedge clk_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
        gap = $urandom % 4;
        repeat (gap) @(posedge clk_i);
    endtask

    task automatic run_wait(input int idx);
        @(posedge clk_i);
        ext_irq_i <= ext_q[idx][`PERIPH_NUM_EXT_IRQ-1:0];
        repeat (wait_q[idx]) @(posedge clk_i);
        @(negedge clk_i);
        check_value("irq_o", {31'b0, irq_o}, irq_exp_q[idx]);
    endtask

    // --------------------------------------------------
    // Watchdog
    // --------------------------------------------------
    initial begin
        wait (vectors_ready === 1'b1);
        repeat (limit_cycles) @(posedge clk_i);
        $display("Timeout: the vectors did not complete within %0d cycles", limit_cycles);
        $display("Simulation FAILED");
        $fatal(1);
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        seed_dummy    = $urandom(90599);
        vectors_ready = 1'b0;
        cur_vec       = 0;
        rst_i         = 1'b1;
        psel_i        = 1'b0;
        penable_i     = 1'b0;
        pwrite_i      = 1'b0;
        paddr_i       = '0;
        pwdata_i      = '0;
        ext_irq_i     = '0;

        load_vectors();
        limit_cycles = RESET_CYCLES + 16 + kind_q.size() * CYCLES_PER_VEC;
        foreach (wait_q[i]) begin
            limit_cycles = limit_cycles + wait_q[i];
        end
        vectors_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;

        for (int i = 0; i < kind_q.size(); i++) begin
            cur_vec = i;
            if (kind_q[i] == 2) begin
                run_wait(i);
            end else begin
                run_transfer(i);
            end
        end

        @(posedge clk_i);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- testbench/periph_vectors.txt
# op addr wdata ext_irq exp_rdata exp_err exp_irq (all hex, op R, W or a decimal wait)
# W compares prdata only when exp_rdata is nonzero, a wait compares irq only
W 00001008 00000030 00 00000000 0 0
R 00001008 00000000 00 00000030 0 0
W 00001000 00000001 00 00000000 0 0
R 00001000 00000000 00 00000001 0 0
W 00001000 00000000 00 00000000 0 0
R 00001004 00000000 00 00000000 0 0
W 00001008 00000005 00 00000000 0 0
W 00000000 00000001 00 00000000 0 0
W 00001000 00000001 00 00000000 0 0
20 00000000 00000000 00 00000000 0 1
R 00000004 00000000 00 00000001 0 1
W 00001000 00000000 00 00000000 0 1
R 00000004 00000000 00 00000000 0 0
W 00000000 00000050 00 00000000 0 0
R 00000008 00000000 28 00000005 0 1
R 00000008 00000000 28 00000007 0 1
R 00000004 00000000 28 00000050 0 0
4 00000000 00000000 00 00000000 0 0
W 00000008 00000005 00 00000000 0 0
W 00000008 00000007 00 00000000 0 0
R 00000008 00000000 00 00000000 0 0
R 00000008 00000000 01 00000000 0 0
R 00000004 00000000 01 00000002 0 0
R 00002000 00000000 00 DEADBEEF 1 0
W 00002008 12345678 00 DEADBEEF 1 0
R 00003004 00000000 00 DEADBEEF 1 0
W 00003000 FFFFFFFF 00 DEADBEEF 1 0
W 00001001 00000001 00 00000000 1 0
W 00001009 00000077 00 00000000 1 0
R 00001008 00000000 00 00000005 0 0
R 00001000 00000000 00 00000000 0 0
R 00000000 00000000 00 00000050 0 0

//--- src.f
+incdir+include
hw/periph_pkg.sv
hw/periph_addr_decode.sv
hw/periph_timer.sv
hw/periph_irq_gateway.sv
hw/periph_resp_mux.sv
hw/ariane_periph_top.sv
testbench/tb_ariane_periph.sv
